// File: design/qpu_settings.svh
`ifndef QPU_SETTINGS_SVH
`define QPU_SETTINGS_SVH

// datapath widths
`define QPU_XLEN         32
`define QPU_TIME_W       32
`define QPU_QUBIT_NUM    8
`define QPU_QIDX_W       3
`define QPU_RIDX_W       4
`define QPU_SIDX_W       4

// instruction buffer depth doubles as the starting credit count
`define QPU_IBUF_DEPTH   4
`define QPU_IBUF_PTR_W   2

// instruction word fields
`define QPU_OP_HI        31
`define QPU_OP_LO        28
`define QPU_RD_HI        27
`define QPU_RD_LO        24
`define QPU_RS1_HI       23
`define QPU_RS1_LO       20
`define QPU_SIDX_HI      19
`define QPU_SIDX_LO      16
`define QPU_IMM_HI       15
`define QPU_IMM_LO       0

`endif

// File: design/qpu_pkg.sv
`default_nettype none

`include "qpu_settings.svh"

package qpu_pkg;

  // opcode field encoding
  typedef enum logic [`QPU_OP_HI-`QPU_OP_LO:0] {
    QOP_NOP     = 4'd0,
    QOP_SMIS    = 4'd1,
    QOP_QWAIT   = 4'd2,
    QOP_ADDI    = 4'd3,
    QOP_GATE    = 4'd4,
    QOP_MEASURE = 4'd5,
    QOP_FMR     = 4'd6
  } qop_e;

  typedef struct packed {
    qop_e                                op;
    logic [`QPU_RD_HI-`QPU_RD_LO:0]     rd;
    logic [`QPU_RS1_HI-`QPU_RS1_LO:0]   rs1;
    logic [`QPU_SIDX_HI-`QPU_SIDX_LO:0] sidx;
    logic [`QPU_IMM_HI-`QPU_IMM_LO:0]   imm;
  } instr_t;

  // timed gate or measure event towards the pulse side
  typedef struct packed {
    logic                      valid;
    qop_e                      op;
    logic [`QPU_TIME_W-1:0]    timestamp;
    logic [`QPU_QUBIT_NUM-1:0] mask;
  } event_t;

  typedef struct packed {
    logic                   valid;
    logic [`QPU_QIDX_W-1:0] qubit;
    logic                   value;
  } meas_t;

  typedef struct packed {
    logic                   valid;
    logic [`QPU_RIDX_W-1:0] rd;
    logic [`QPU_XLEN-1:0]   data;
  } wbck_t;

  typedef struct packed {
    logic                   valid;
    logic [`QPU_RIDX_W-1:0] rd;
    logic [`QPU_QIDX_W-1:0] qubit;
  } fmr_req_t;

endpackage

`default_nettype wire

// File: design/qpu_ibuf.sv
`timescale 1ns/1ps
`default_nettype none

`include "qpu_settings.svh"

module qpu_ibuf (
  input  wire                 clk,
  input  wire                 i_rst_n,
  input  wire                 i_valid,
  input  qpu_pkg::instr_t     i_instr,
  input  wire                 i_pop,
  output logic                o_head_valid,
  output qpu_pkg::instr_t     o_head,
  output logic                o_credit
);

  qpu_pkg::instr_t mem [0:`QPU_IBUF_DEPTH-1];

  // extra msb tells full from empty
  logic [`QPU_IBUF_PTR_W:0] wptr;
  logic [`QPU_IBUF_PTR_W:0] rptr;

  assign o_head_valid = (wptr != rptr);
  assign o_head       = mem[rptr[`QPU_IBUF_PTR_W-1:0]];

  // writes are bounded by the credits held at the source
  always_ff @(posedge clk)
  begin
    if (i_valid)
      mem[wptr[`QPU_IBUF_PTR_W-1:0]] <= i_instr;
  end

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      wptr     <= '0;
      rptr     <= '0;
      o_credit <= 1'b0;
    end
    else
    begin
      if (i_valid)
        wptr <= wptr + 1'b1;
      if (i_pop)
        rptr <= rptr + 1'b1;
      // one credit back per popped entry
      o_credit <= i_pop;
    end
  end

endmodule

`default_nettype wire

// File: design/qpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "qpu_settings.svh"

module qpu_regfile (
  input  wire                        clk,
  input  wire                        i_rst_n,
  input  wire  [`QPU_RIDX_W-1:0]     i_rs1,
  output logic [`QPU_XLEN-1:0]       o_rs1_data,
  input  wire  [`QPU_SIDX_W-1:0]     i_sidx,
  output logic [`QPU_QUBIT_NUM-1:0]  o_mask,
  input  qpu_pkg::wbck_t             i_cwr,
  input  wire                        i_swr_en,
  input  wire  [`QPU_SIDX_W-1:0]     i_swr_idx,
  input  wire  [`QPU_QUBIT_NUM-1:0]  i_swr_mask
);

  logic [`QPU_XLEN-1:0]      creg [0:(1<<`QPU_RIDX_W)-1];
  logic [`QPU_QUBIT_NUM-1:0] sreg [0:(1<<`QPU_SIDX_W)-1];

  // async read ports
  assign o_rs1_data = creg[i_rs1];
  assign o_mask     = sreg[i_sidx];

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      for (int i = 0; i < (1<<`QPU_RIDX_W); i++)
        creg[i] <= '0;
      for (int i = 0; i < (1<<`QPU_SIDX_W); i++)
        sreg[i] <= '0;
    end
    else
    begin
      // r0 is hardwired, never written
      if (i_cwr.valid && (i_cwr.rd != '0))
        creg[i_cwr.rd] <= i_cwr.data;
      if (i_swr_en)
        sreg[i_swr_idx] <= i_swr_mask;
    end
  end

endmodule

`default_nettype wire

// File: design/qpu_disp.sv
`timescale 1ns/1ps
`default_nettype none

`include "qpu_settings.svh"

module qpu_disp (
  input  wire                        clk,
  input  wire                        i_rst_n,
  input  wire                        i_head_valid,
  input  qpu_pkg::instr_t            i_head,
  output logic                       o_pop,
  output logic [`QPU_RIDX_W-1:0]     o_rs1,
  input  wire  [`QPU_XLEN-1:0]       i_rs1_data,
  output logic [`QPU_SIDX_W-1:0]     o_sidx,
  input  wire  [`QPU_QUBIT_NUM-1:0]  i_mask,
  output qpu_pkg::wbck_t             o_cwr,
  output logic                       o_swr_en,
  output logic [`QPU_SIDX_W-1:0]     o_swr_idx,
  output logic [`QPU_QUBIT_NUM-1:0]  o_swr_mask,
  output logic [`QPU_QUBIT_NUM-1:0]  o_meas_set,
  output qpu_pkg::fmr_req_t          o_fmr,
  input  wire                        i_busy,
  output qpu_pkg::event_t            o_event
);

  localparam int IMM_W = `QPU_IMM_HI - `QPU_IMM_LO + 1;

  qpu_pkg::qop_e          head_op;
  logic [`QPU_TIME_W-1:0] timeline;
  logic [`QPU_XLEN-1:0]   imm_sext;
  logic                   do_smis;
  logic                   do_qwait;
  logic                   do_addi;
  logic                   do_event;
  logic                   do_meas;
  logic                   do_fmr;

  //////////////////////////////////////////////////////////////////////
  // in-order decode held off while an FMR is open

  assign head_op = i_head.op;
  assign o_pop   = i_head_valid && !i_busy;

  always_comb
  begin
    do_smis  = 1'b0;
    do_qwait = 1'b0;
    do_addi  = 1'b0;
    do_event = 1'b0;
    do_meas  = 1'b0;
    do_fmr   = 1'b0;
    if (o_pop)
    begin
      case (head_op)
        qpu_pkg::QOP_SMIS:    do_smis  = 1'b1;
        qpu_pkg::QOP_QWAIT:   do_qwait = 1'b1;
        qpu_pkg::QOP_ADDI:    do_addi  = 1'b1;
        qpu_pkg::QOP_GATE:    do_event = 1'b1;
        qpu_pkg::QOP_MEASURE:
        begin
          do_event = 1'b1;
          do_meas  = 1'b1;
        end
        qpu_pkg::QOP_FMR:     do_fmr   = 1'b1;
        // NOP and unused codes just retire
        default:              do_smis  = 1'b0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // register file access and requests

  assign o_rs1    = i_head.rs1;
  assign o_sidx   = i_head.sidx;
  assign imm_sext = {{(`QPU_XLEN-IMM_W){i_head.imm[IMM_W-1]}}, i_head.imm};

  always_comb
  begin
    o_cwr.valid = do_addi;
    o_cwr.rd    = i_head.rd;
    o_cwr.data  = i_rs1_data + imm_sext;
  end

  assign o_swr_en   = do_smis;
  assign o_swr_idx  = i_head.sidx;
  assign o_swr_mask = i_head.imm[`QPU_QUBIT_NUM-1:0];

  // mark measured qubits pending
  assign o_meas_set = do_meas ? i_mask : '0;

  always_comb
  begin
    o_fmr.valid = do_fmr;
    o_fmr.rd    = i_head.rd;
    o_fmr.qubit = i_head.imm[`QPU_QIDX_W-1:0];
  end

  //////////////////////////////////////////////////////////////////////
  // timeline and event output

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      timeline <= '0;
      o_event  <= '0;
    end
    else
    begin
      if (do_qwait)
        timeline <= timeline + {{(`QPU_TIME_W-IMM_W){1'b0}}, i_head.imm};
      // event is stamped with the time before any later qwait
      o_event.valid     <= do_event;
      o_event.op        <= head_op;
      o_event.timestamp <= timeline;
      o_event.mask      <= i_mask;
    end
  end

endmodule

`default_nettype wire

// File: design/qpu_qubit_slot.sv
`timescale 1ns/1ps
`default_nettype none

`include "qpu_settings.svh"

module qpu_qubit_slot #(
  parameter logic [`QPU_QIDX_W-1:0] QUBIT_IDX = '0
) (
  input  wire           clk,
  input  wire           i_rst_n,
  input  wire           i_set,
  input  qpu_pkg::meas_t i_meas,
  output logic          o_pending,
  output logic          o_result
);

  logic hit;

  assign hit = i_meas.valid && (i_meas.qubit == QUBIT_IDX);

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_pending <= 1'b0;
      o_result  <= 1'b0;
    end
    else
    begin
      if (hit)
        o_result <= i_meas.value;
      // a new measure wins over a result landing in the same cycle
      if (i_set)
        o_pending <= 1'b1;
      else if (hit)
        o_pending <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/qpu_wbck.sv
`timescale 1ns/1ps
`default_nettype none

`include "qpu_settings.svh"

module qpu_wbck (
  input  wire                        clk,
  input  wire                        i_rst_n,
  input  qpu_pkg::wbck_t             i_cwr,
  input  qpu_pkg::fmr_req_t          i_fmr,
  input  wire  [`QPU_QUBIT_NUM-1:0]  i_pending,
  input  wire  [`QPU_QUBIT_NUM-1:0]  i_result,
  output logic                       o_busy,
  output qpu_pkg::wbck_t             o_fmr_wr,
  output qpu_pkg::wbck_t             o_wbck
);

  logic                   fmr_wait;
  logic [`QPU_RIDX_W-1:0] fmr_rd;
  logic [`QPU_QIDX_W-1:0] fmr_qubit;
  logic                   fmr_done;
  qpu_pkg::wbck_t         fmr_res;
  qpu_pkg::wbck_t         cwr_q;

  // done as soon as the tracked qubit has no result outstanding
  assign fmr_done = fmr_wait && !i_pending[fmr_qubit];
  assign o_busy   = fmr_wait;

  always_comb
  begin
    fmr_res.valid = fmr_done;
    fmr_res.rd    = fmr_rd;
    fmr_res.data  = {{(`QPU_XLEN-1){1'b0}}, i_result[fmr_qubit]};
  end

  // the FMR result borrows the regfile write port while dispatch is stalled
  assign o_fmr_wr = fmr_done ? fmr_res : i_cwr;
  assign o_wbck   = fmr_done ? fmr_res : cwr_q;

  always_ff @(posedge clk)
  begin
    if (i_fmr.valid)
    begin
      fmr_rd    <= i_fmr.rd;
      fmr_qubit <= i_fmr.qubit;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      fmr_wait <= 1'b0;
      cwr_q    <= '0;
    end
    else
    begin
      if (i_fmr.valid)
        fmr_wait <= 1'b1;
      else if (fmr_done)
        fmr_wait <= 1'b0;
      // addi result shows up one cycle after its pop
      cwr_q <= i_cwr;
    end
  end

endmodule

`default_nettype wire

// File: design/qpu_exu.sv
`timescale 1ns/1ps
`default_nettype none

`include "qpu_settings.svh"

module qpu_exu (
  input  wire                clk,
  input  wire                i_rst_n,
  input  wire                i_instr_valid,
  input  qpu_pkg::instr_t    i_instr,
  output logic               o_credit,
  input  qpu_pkg::meas_t     i_meas,
  output qpu_pkg::event_t    o_event,
  output qpu_pkg::wbck_t     o_wbck
);

  logic                      head_valid;
  qpu_pkg::instr_t           head;
  logic                      pop;
  logic [`QPU_RIDX_W-1:0]    rs1;
  logic [`QPU_XLEN-1:0]      rs1_data;
  logic [`QPU_SIDX_W-1:0]    sidx;
  logic [`QPU_QUBIT_NUM-1:0] mask;
  qpu_pkg::wbck_t            cwr;
  logic                      swr_en;
  logic [`QPU_SIDX_W-1:0]    swr_idx;
  logic [`QPU_QUBIT_NUM-1:0] swr_mask;
  logic [`QPU_QUBIT_NUM-1:0] meas_set;
  qpu_pkg::fmr_req_t         fmr;
  logic                      busy;
  logic [`QPU_QUBIT_NUM-1:0] pending;
  logic [`QPU_QUBIT_NUM-1:0] result;
  qpu_pkg::wbck_t            fmr_wr;

  //////////////////////////////////////////////////////////////////////
  // buffer, register file and dispatch

  qpu_ibuf u_ibuf (
    .clk          (clk          ),
    .i_rst_n      (i_rst_n      ),
    .i_valid      (i_instr_valid),
    .i_instr      (i_instr      ),
    .i_pop        (pop          ),
    .o_head_valid (head_valid   ),
    .o_head       (head         ),
    .o_credit     (o_credit     )
  );

  qpu_regfile u_regfile (
    .clk        (clk     ),
    .i_rst_n    (i_rst_n ),
    .i_rs1      (rs1     ),
    .o_rs1_data (rs1_data),
    .i_sidx     (sidx    ),
    .o_mask     (mask    ),
    .i_cwr      (fmr_wr  ),
    .i_swr_en   (swr_en  ),
    .i_swr_idx  (swr_idx ),
    .i_swr_mask (swr_mask)
  );

  qpu_disp u_disp (
    .clk          (clk       ),
    .i_rst_n      (i_rst_n   ),
    .i_head_valid (head_valid),
    .i_head       (head      ),
    .o_pop        (pop       ),
    .o_rs1        (rs1       ),
    .i_rs1_data   (rs1_data  ),
    .o_sidx       (sidx      ),
    .i_mask       (mask      ),
    .o_cwr        (cwr       ),
    .o_swr_en     (swr_en    ),
    .o_swr_idx    (swr_idx   ),
    .o_swr_mask   (swr_mask  ),
    .o_meas_set   (meas_set  ),
    .o_fmr        (fmr       ),
    .i_busy       (busy      ),
    .o_event      (o_event   )
  );

  //////////////////////////////////////////////////////////////////////
  // per-qubit trackers and writeback

  genvar g_q;
  generate
    for (g_q = 0; g_q < `QPU_QUBIT_NUM; g_q++)
    begin : g_slot
      qpu_qubit_slot #(
        .QUBIT_IDX (`QPU_QIDX_W'(g_q))
      ) u_slot (
        .clk       (clk          ),
        .i_rst_n   (i_rst_n      ),
        .i_set     (meas_set[g_q]),
        .i_meas    (i_meas       ),
        .o_pending (pending[g_q] ),
        .o_result  (result[g_q]  )
      );
    end
  endgenerate

  qpu_wbck u_wbck (
    .clk       (clk    ),
    .i_rst_n   (i_rst_n),
    .i_cwr     (cwr    ),
    .i_fmr     (fmr    ),
    .i_pending (pending),
    .i_result  (result ),
    .o_busy    (busy   ),
    .o_fmr_wr  (fmr_wr ),
    .o_wbck    (o_wbck )
  );

endmodule

`default_nettype wire

// File: verif/tb_qpu_exu.sv
`timescale 1ns/1ps
`default_nettype none

`include "qpu_settings.svh"

module tb_qpu_exu;

  localparam int         MAX_LINES  = 64;
  localparam logic [3:0] KIND_PLAIN = 4'h0;
  localparam logic [3:0] KIND_EVENT = 4'h1;
  localparam logic [3:0] KIND_WBCK  = 4'h2;
  localparam logic [3:0] KIND_MEAS  = 4'h3;
  localparam logic [3:0] KIND_HELD  = 4'h4;
  localparam logic [3:0] KIND_END   = 4'hf;

  // one output still owed by the DUT in pop order
  typedef struct packed {
    logic                   is_event;
    logic                   held;
    logic [`QPU_QIDX_W-1:0] qubit;
    int                     seq;
    logic [47:0]            value;
  } expect_t;

  logic            clk = 1'b0;
  logic            i_rst_n;
  logic            i_instr_valid;
  qpu_pkg::instr_t i_instr;
  logic            o_credit;
  qpu_pkg::meas_t  i_meas;
  qpu_pkg::event_t o_event;
  qpu_pkg::wbck_t  o_wbck;

  logic [47:0]     stim [0:3*MAX_LINES-1];
  expect_t         exp_mem [0:MAX_LINES-1];
  int              exp_wr = 0;
  int              exp_rd = 0;
  int              n_lines = 0;
  int              sent = 0;
  int              fence = 0;
  int              credits_back = 0;
  int              mismatch_cnt = 0;
  int              other_cnt = 0;
  int              seed;
  logic            just_released = 1'b0;
  qpu_pkg::meas_t  meas_prev = '0;

  always #4 clk = ~clk;

  qpu_exu i_qpu_exu (
    .clk           (clk          ),
    .i_rst_n       (i_rst_n      ),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr      ),
    .o_credit      (o_credit     ),
    .i_meas        (i_meas       ),
    .o_event       (o_event      ),
    .o_wbck        (o_wbck       )
  );

  //////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_event(input qpu_pkg::event_t act, input qpu_pkg::event_t exp);
    if (act !== exp)
    begin
      mismatch_cnt++;
      $display("MISMATCH @%0t: event op %0d ts %0h mask %02h, expected op %0d ts %0h mask %02h",
               $time, act.op, act.timestamp, act.mask, exp.op, exp.timestamp, exp.mask);
    end
  endtask

  task automatic check_wbck(input qpu_pkg::wbck_t act, input qpu_pkg::wbck_t exp);
    if (act !== exp)
    begin
      mismatch_cnt++;
      $display("MISMATCH @%0t: wbck rd %0d data %0h, expected rd %0d data %0h",
               $time, act.rd, act.data, exp.rd, exp.data);
    end
  endtask

  task automatic check_idle();
    if (o_credit !== 1'b0 || o_event.valid !== 1'b0 || o_wbck.valid !== 1'b0)
    begin
      other_cnt++;
      $display("outputs not idle around reset at %0t", $time);
    end
  endtask

  // match the current output against the oldest owed one
  task automatic match_output();
    expect_t         e;
    qpu_pkg::event_t ev_exp;
    qpu_pkg::wbck_t  wb_exp;
    if (o_event.valid && o_wbck.valid)
    begin
      other_cnt++;
      $display("event and writeback in the same cycle at %0t", $time);
    end
    else if (exp_rd == exp_wr)
    begin
      other_cnt++;
      $display("unexpected output at %0t with nothing owed", $time);
    end
    else
    begin
      e = exp_mem[exp_rd];
      exp_rd++;
      ev_exp = e.value[$bits(qpu_pkg::event_t)-1:0];
      wb_exp = e.value[$bits(qpu_pkg::wbck_t)-1:0];
      if (e.is_event != o_event.valid)
      begin
        other_cnt++;
        $display("output at %0t is not the kind expected next", $time);
      end
      else if (e.is_event)
        check_event(o_event, ev_exp);
      else
        check_wbck(o_wbck, wb_exp);
      // a stalled FMR ends one cycle after its measurement, the rest after their pop
      if (e.held)
      begin
        if (!meas_prev.valid || meas_prev.qubit != e.qubit)
        begin
          other_cnt++;
          $display("FMR result at %0t not one cycle after the measurement of qubit %0d",
                   $time, e.qubit);
        end
      end
      else if (!o_credit || credits_back != e.seq)
      begin
        other_cnt++;
        $display("output at %0t is not one cycle after the pop of instruction %0d",
                 $time, e.seq);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitor samples settled values at the rising edge

  always @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      check_idle();
      just_released = 1'b1;
    end
    else
    begin
      if (just_released)
        check_idle();
      just_released = 1'b0;
      if (o_credit)
        credits_back++;
      if (credits_back > sent)
      begin
        other_cnt++;
        $display("more credits returned than instructions sent at %0t", $time);
      end
      if (o_event.valid || o_wbck.valid)
        match_output();
      meas_prev = i_meas;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // driver works on the falling edge

  task automatic send_instr(input logic [31:0] word, input logic [3:0] kind,
                            input logic [47:0] expv);
    qpu_pkg::instr_t ins;
    expect_t         e;
    int              gap;
    ins = word;
    gap = $unsigned($random(seed)) % 4;
    repeat (gap) @(negedge clk);
    // hold off while the source has no credit left
    while (`QPU_IBUF_DEPTH - (sent - credits_back) <= 0)
      @(negedge clk);
    i_instr_valid = 1'b1;
    i_instr       = ins;
    sent++;
    if (ins.op == qpu_pkg::QOP_MEASURE || ins.op == qpu_pkg::QOP_FMR)
      fence = sent;
    if (kind == KIND_EVENT || kind == KIND_WBCK || kind == KIND_HELD)
    begin
      e.is_event       = (kind == KIND_EVENT);
      e.held           = (kind == KIND_HELD);
      e.qubit          = ins.imm[`QPU_QIDX_W-1:0];
      e.seq            = sent;
      e.value          = expv;
      exp_mem[exp_wr]  = e;
      exp_wr++;
    end
    @(negedge clk);
    i_instr_valid = 1'b0;
  endtask

  // measurement lands only once the last MEASURE or FMR has been popped
  task automatic inject_meas(input qpu_pkg::meas_t m);
    int gap;
    gap = 1 + $unsigned($random(seed)) % 4;
    while (credits_back < fence)
      @(negedge clk);
    repeat (gap) @(negedge clk);
    i_meas = m;
    @(negedge clk);
    i_meas = '0;
  endtask

  initial
  begin
    logic [3:0] kind;
    i_rst_n       = 1'b0;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    i_meas        = '0;
    seed          = 32'hc20e;
    $readmemh("verif/qpu_stim.txt", stim);
    while (n_lines < MAX_LINES && stim[3*n_lines][3:0] != KIND_END)
      n_lines++;
    if (n_lines == 0)
    begin
      other_cnt++;
      $display("no stimulus lines read from verif/qpu_stim.txt");
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;
    for (int i = 0; i < n_lines; i++)
    begin
      kind = stim[3*i][3:0];
      if (kind == KIND_MEAS)
        inject_meas(stim[3*i+1][`QPU_QIDX_W+1:0]);
      else if (kind != KIND_PLAIN || stim[3*i+2] == '0)
        send_instr(stim[3*i+1][31:0], kind, stim[3*i+2]);
    end
    // drain, then leave room for stray outputs
    while (exp_rd != exp_wr || credits_back != sent)
      @(negedge clk);
    repeat (4) @(negedge clk);
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // watchdog scaled to the stimulus length
  initial
  begin
    wait (n_lines > 0);
    repeat (n_lines * 40) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", n_lines * 40);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/qpu_stim.txt
// kind word expect; kind 0 plain, 1 event, 2 wbck, 3 meas, 4 held FMR, f end
// event = {valid,op,timestamp,mask}, wbck = {valid,rd,data}, meas = {valid,qubit,value}
0 10010005 0             // smis s1 0x05
0 10020082 0             // smis s2 0x82
0 2000000A 0             // qwait 10
1 40010000 140000000A05  // gate s1
2 31000005 1100000005    // addi r1 r0 5
2 32100003 1200000008    // addi r2 r1 3
2 3220FFFF 1200000007    // addi r2 r2 -1
2 30200010 1000000017    // addi r0 r2 0x10
2 33000001 1300000001    // addi r3 r0 1
0 20000020 0             // qwait 0x20
1 50020000 150000002A82  // measure s2
4 64000007 1400000001    // fmr r4 q7, waits
2 35400002 1500000003    // addi r5 r4 2
1 40020000 140000002A82  // gate s2
3 1F 0                   // meas q7 1
3 13 0                   // meas q1 1
2 66000001 1600000001    // fmr r6 q1
2 67000003 1700000000    // fmr r7 q3, never measured
2 38600100 1800000101    // addi r8 r6 0x100
0 20000005 0             // qwait 5
1 50010000 150000002F05  // measure s1
0 00000000 0             // nop
4 69000002 1900000000    // fmr r9 q2, waits
3 14 0                   // meas q2 0
2 6A000007 1A00000001    // fmr r10 q7
2 3B900007 1B00000007    // addi r11 r9 7
f 0 0

// File: build.f
+incdir+design
design/qpu_pkg.sv
design/qpu_ibuf.sv
design/qpu_regfile.sv
design/qpu_disp.sv
design/qpu_qubit_slot.sv
design/qpu_wbck.sv
design/qpu_exu.sv
verif/tb_qpu_exu.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator from the project root
cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter project root"
  exit 1
fi

verilator --binary --timing -j 0 --top-module tb_qpu_exu -f build.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1
